//--- cr_quantizer.f
rtl/quant_pkg.sv
rtl/quant_table_regs.sv
rtl/quant_pipeline.sv
rtl/cr_quantizer.sv
tb/quant_checker.sv
tb/tb_cr_quantizer.sv

//--- rtl/cr_quantizer.sv
// Cr quantizer top; table must be loaded over APB before streaming if steps other than 1 are wanted
module cr_quantizer
    import quant_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // APB configuration port
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [APB_ADDR_W-1:0]    paddr,
    input  logic [APB_DATA_W-1:0]    pwdata,
    output logic [APB_DATA_W-1:0]    prdata,
    output logic                     pready,
    output logic                     pslverr,

    // Coefficient stream in
    input  logic                     in_valid,
    input  logic signed [COEF_W-1:0] in_coef,
    input  logic [IDX_W-1:0]         in_index,

    // Quantized stream out
    output logic                     out_valid,
    output logic signed [COEF_W-1:0] out_coef,
    output logic [IDX_W-1:0]         out_index
);

    logic [IDX_W-1:0]  lookup_index;
    logic [MULT_W-1:0] lookup_mult;

    // ----------------------------------------
    // Reciprocal table
    // ----------------------------------------

    quant_table_regs u_table (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .lookup_index (lookup_index),
        .lookup_mult  (lookup_mult)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    quant_pipeline u_pipeline (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_coef      (in_coef),
        .in_index     (in_index),
        .lookup_index (lookup_index),
        .lookup_mult  (lookup_mult),
        .out_valid    (out_valid),
        .out_coef     (out_coef),
        .out_index    (out_index)
    );

endmodule

//--- rtl/quant_pipeline.sv
// Four-cycle quantizer datapath with no back-pressure; uses the table entry present when stage 1 holds the item
module quant_pipeline
    import quant_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // Coefficient stream in, one per cycle
    input  logic                     in_valid,
    input  logic signed [COEF_W-1:0] in_coef,
    input  logic [IDX_W-1:0]         in_index,

    // Table lookup for the stage 1 position
    output logic [IDX_W-1:0]         lookup_index,
    input  logic [MULT_W-1:0]        lookup_mult,

    // Quantized stream out
    output logic                     out_valid,
    output logic signed [COEF_W-1:0] out_coef,
    output logic [IDX_W-1:0]         out_index
);

    logic                     s1_valid;
    logic signed [PROD_W-1:0] s1_coef;
    logic [IDX_W-1:0]         s1_index;

    logic                     s2_valid;
    logic signed [PROD_W-1:0] s2_prod;
    logic [IDX_W-1:0]         s2_index;

    logic                     s3_valid;
    logic signed [PROD_W-1:0] s3_prod;
    logic [IDX_W-1:0]         s3_index;

    logic signed [PROD_W-1:0] mult_ext;
    logic signed [PROD_W-1:0] s3_shift;
    logic signed [PROD_W-1:0] s3_round;

    // ----------------------------------------
    // Valid chain
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            out_valid <= s3_valid;
        end
    end

    // ----------------------------------------
    // Stage 1 and 2: sign extend, multiply
    // ----------------------------------------

    // Multiplier is unsigned, so it goes in with a zero top bit
    assign mult_ext     = $signed({{(PROD_W - MULT_W){1'b0}}, lookup_mult});
    assign lookup_index = s1_index;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_coef  <= '0;
            s1_index <= '0;
            s2_prod  <= '0;
            s2_index <= '0;
        end else begin
            if (in_valid) begin
                s1_coef  <= {{(PROD_W - COEF_W){in_coef[COEF_W-1]}}, in_coef};
                s1_index <= in_index;
            end
            // |coef * mult| stays within 2^22, so the 24-bit product never wraps
            if (s1_valid) begin
                s2_prod  <= s1_coef * mult_ext;
                s2_index <= s1_index;
            end
        end
    end

    // ----------------------------------------
    // Stage 3 and 4: hold product, round
    // ----------------------------------------

    // Arithmetic shift kept on its own so the rounding add cannot turn it logical
    assign s3_shift = s3_prod >>> FRAC_BITS;
    assign s3_round = s3_shift + {{(PROD_W - 1){1'b0}}, s3_prod[FRAC_BITS-1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s3_prod   <= '0;
            s3_index  <= '0;
            out_coef  <= '0;
            out_index <= '0;
        end else begin
            if (s2_valid) begin
                s3_prod  <= s2_prod;
                s3_index <= s2_index;
            end
            // Outputs hold their last values across gaps
            if (s3_valid) begin
                out_coef  <= s3_round[COEF_W-1:0];
                out_index <= s3_index;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Latency through all four stages is fixed at four cycles
    a_latency_four : assert property (
        @(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 4)
    ) else $error("out_valid does not follow in_valid by four cycles");

endmodule

//--- rtl/quant_pkg.sv
// Shared widths for the Cr quantizer; multipliers are 4096/Q in 1..4096, one APB word per entry
package quant_pkg;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------

    // Signed DCT coefficient in and quantized coefficient out
    localparam int COEF_W = 11;

    // Unsigned reciprocal multiplier, scaled by 2^FRAC_BITS
    localparam int MULT_W = 13;

    // Signed product, wide enough for -1024 * 4096
    localparam int PROD_W = 24;

    localparam int FRAC_BITS = 12;

    // Multiplier for a quantization step of 1
    localparam int MULT_ONE = 4096;

    // ----------------------------------------
    // Block layout
    // ----------------------------------------

    localparam int BLOCK_SIZE = 64;
    localparam int IDX_W = 6;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Entries sit on word boundaries, so the index starts at address bit 2
    localparam int APB_IDX_LSB = 2;

endpackage

//--- rtl/quant_table_regs.sv
// APB slave with zero wait states; writes of 0 or above 4096 are dropped with pslverr, paddr[1:0] ignored
module quant_table_regs
    import quant_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,

    // Lookup port for the pipeline
    input  logic [IDX_W-1:0]      lookup_index,
    output logic [MULT_W-1:0]     lookup_mult
);

    logic [MULT_W-1:0] table_mem [BLOCK_SIZE];

    logic              access;
    logic              wr_access;
    logic              rd_access;
    logic              wr_data_ok;
    logic              wr_en;
    logic [IDX_W-1:0]  apb_idx;

    // ----------------------------------------
    // APB decode
    // ----------------------------------------

    // The access phase of a transfer is the second cycle with psel held
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    assign apb_idx = paddr[APB_IDX_LSB +: IDX_W];

    // A zero multiplier would wipe the coefficient and anything over one step is meaningless
    assign wr_data_ok = (pwdata != '0) && (pwdata <= APB_DATA_W'(MULT_ONE));
    assign wr_en      = wr_access && wr_data_ok;

    assign pready  = 1'b1;
    assign pslverr = wr_access && !wr_data_ok;

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            prdata = {{(APB_DATA_W - MULT_W){1'b0}}, table_mem[apb_idx]};
        end
    end

    // ----------------------------------------
    // Multiplier table
    // ----------------------------------------

    // Every entry comes out of reset as a step of 1, so an unprogrammed table passes data through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                table_mem[i] <= MULT_W'(MULT_ONE);
            end
        end else if (wr_en) begin
            table_mem[apb_idx] <= pwdata[MULT_W-1:0];
        end
    end

    // Combinational read for stage 2 of the pipeline
    assign lookup_mult = table_mem[lookup_index];

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // The range check on writes keeps every entry nonzero for the multiplier
    a_lookup_nonzero : assert property (
        @(posedge clk) disable iff (rst)
        lookup_mult != '0
    ) else $error("zero multiplier reached the pipeline");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; run from any directory
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cr_quantizer.f \
    --top-module tb_cr_quantizer -Mdir obj_dir
./obj_dir/Vtb_cr_quantizer > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

//--- tb/cr_quantizer_trace.txt
# op test f1 f2 f3 f4 in decimal; W: byte_addr data exp_pslverr 0; R: byte_addr exp_prdata 0 0
# C: position coef exp_out gap_after; S: first_position count coef exp_out (back-to-back sweep)
R reset_defaults 0 4096 0 0
R reset_defaults 124 4096 0 0
R reset_defaults 252 4096 0 0
S full_block 0 64 -300 -300
W table_access 0 16 0 0
R table_access 0 16 0 0
W table_access 4 1365 0 0
W table_access 8 819 0 0
W table_access 20 372 0 0
W table_access 252 2731 0 0
R table_access 252 2731 0 0
W table_access 20 0 1 0
W table_access 20 5000 1 0
R table_access 20 372 0 0
W table_access 40 4096 0 0
W table_access 40 4097 1 0
R table_access 40 4096 0 0
C quant_rule 0 1000 4 0
C quant_rule 0 -1000 -4 0
C quant_rule 0 -1024 -4 0
C quant_rule 0 1023 4 0
C quant_rule 1 0 0 0
C quant_rule 1 -100 -33 0
C quant_rule 1 1023 341 0
C quant_rule 1 -1024 -341 0
C quant_rule 2 8 2 0
C quant_rule 2 -7 -1 0
C quant_rule 63 1023 682 0
C quant_rule 63 -1024 -683 0
C quant_rule 10 -1024 -1024 0
C quant_rule 31 1023 1023 0
C gaps 5 500 45 1
C gaps 5 -500 -45 1
C gaps 2 7 1 0
C gaps 2 -8 -2 1
C gaps 1 100 33 0

//--- tb/quant_checker.sv
// Samples the DUT at the falling edge; expected results must be queued while their input is driven
module quant_checker
    import quant_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic                     psel,
    input logic                     penable,
    input logic [APB_ADDR_W-1:0]    paddr,
    input logic [APB_DATA_W-1:0]    prdata,
    input logic                     pready,
    input logic                     pslverr,
    input logic                     out_valid,
    input logic signed [COEF_W-1:0] out_coef,
    input logic [IDX_W-1:0]         out_index
);
    timeunit 1ns;
    timeprecision 100ps;

    int    errors = 0;
    int    cyc = 0;
    string cname_q[$];
    int    cidx_q[$];
    int    cval_q[$];
    int    cdue_q[$];
    string aname_q[$];
    bit    awrite_q[$];
    int    aexp_q[$];
    string last_name = "reset";
    logic signed [COEF_W-1:0] last_coef = '0;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Four register stages lie between in_valid and out_valid
    task automatic expect_coef(input string name, input int index, input int value);
        cname_q.push_back(name);
        cidx_q.push_back(index);
        cval_q.push_back(value);
        cdue_q.push_back(cyc + 4);
    endtask

    task automatic expect_apb(input string name, input bit write, input int value);
        aname_q.push_back(name);
        awrite_q.push_back(write);
        aexp_q.push_back(value);
    endtask

    function automatic int outstanding();
        return cdue_q.size();
    endfunction

    always @(negedge clk) begin : compare
        string nm;
        bit    wr;
        int    expv;
        int    idx;
        int    due;
        if (!rst && psel && penable) begin
            if (aname_q.size() == 0) begin
                $display("APB access at address %0d had no expected response", paddr);
                errors++;
            end else begin
                nm   = aname_q.pop_front();
                wr   = awrite_q.pop_front();
                expv = aexp_q.pop_front();
                if (!pready) begin
                    $display("pready was low in the access cycle of %s", nm);
                    errors++;
                end
                if (wr && pslverr != expv[0]) begin
                    $display("Error %s: pslverr expected %0d, got %0d", nm, expv[0], pslverr);
                    errors++;
                end
                if (!wr && prdata != APB_DATA_W'(expv)) begin
                    $display("Error %s: prdata expected %0d, got %0d", nm, expv, prdata);
                    errors++;
                end
                if (!wr && pslverr) begin
                    $display("pslverr was raised on a read in %s", nm);
                    errors++;
                end
            end
        end
        if (!rst) begin
            if (out_valid) begin
                if (cdue_q.size() == 0) begin
                    $display("out_valid was high at position %0d with nothing expected", out_index);
                    errors++;
                end else begin
                    nm        = cname_q.pop_front();
                    idx       = cidx_q.pop_front();
                    expv      = cval_q.pop_front();
                    due       = cdue_q.pop_front();
                    last_name = nm;
                    if (due != cyc) begin
                        $display("Error %s: output cycle expected %0d, got %0d", nm, due, cyc);
                        errors++;
                    end
                    if (int'(out_index) != idx) begin
                        $display("Error %s: out_index expected %0d, got %0d", nm, idx, out_index);
                        errors++;
                    end
                    if (int'(out_coef) != expv) begin
                        $display("Error %s: out_coef expected %0d, got %0d", nm, expv, out_coef);
                        errors++;
                    end
                end
            end else begin
                if (cdue_q.size() != 0 && cdue_q[0] <= cyc) begin
                    $display("A result for %s did not appear, out_valid stayed low", cname_q[0]);
                    errors++;
                    void'(cname_q.pop_front());
                    void'(cidx_q.pop_front());
                    void'(cval_q.pop_front());
                    void'(cdue_q.pop_front());
                end
                // Outputs must hold across cycles without a valid result
                if (out_coef != last_coef) begin
                    $display("Error %s: held out_coef expected %0d, got %0d",
                             last_name, last_coef, out_coef);
                    errors++;
                end
            end
            last_coef = out_coef;
        end
    end

endmodule

//--- tb/tb_cr_quantizer.sv
// Runs every operation of tb/cr_quantizer_trace.txt in order; simulate from the project root
module tb_cr_quantizer
    import quant_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk;
    logic                     rst;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_W-1:0]    paddr;
    logic [APB_DATA_W-1:0]    pwdata;
    logic [APB_DATA_W-1:0]    prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     in_valid;
    logic signed [COEF_W-1:0] in_coef;
    logic [IDX_W-1:0]         in_index;
    logic                     out_valid;
    logic signed [COEF_W-1:0] out_coef;
    logic [IDX_W-1:0]         out_index;

    string op_q[$];
    string name_q[$];
    int    f1_q[$];
    int    f2_q[$];
    int    f3_q[$];
    int    f4_q[$];
    int    ops_total = 0;
    int    load_errors = 0;
    int    tests_ok = 0;
    int    tests_bad = 0;
    int    errors_at_start = 0;
    string cur_test;

    cr_quantizer dut (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_valid  (in_valid),
        .in_coef   (in_coef),
        .in_index  (in_index),
        .out_valid (out_valid),
        .out_coef  (out_coef),
        .out_index (out_index)
    );

    quant_checker u_check (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_valid (out_valid),
        .out_coef  (out_coef),
        .out_index (out_index)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Trace reading
    // ----------------------------------------

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        string op;
        string nm;
        int    a;
        int    b;
        int    c;
        int    d;
        fd = $fopen("tb/cr_quantizer_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file tb/cr_quantizer_trace.txt could not be opened");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %d %d %d %d", op, nm, a, b, c, d);
                    if (n == 6) begin
                        op_q.push_back(op);
                        name_q.push_back(nm);
                        f1_q.push_back(a);
                        f2_q.push_back(b);
                        f3_q.push_back(c);
                        f4_q.push_back(d);
                    end else begin
                        $display("A trace line could not be read: %s", line);
                        load_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        ops_total = op_q.size();
    endtask

    // ----------------------------------------
    // Bus and stream drivers
    // ----------------------------------------

    // For a write, expv is the expected pslverr; for a read, the expected prdata
    task automatic apb_transfer(input string name, input bit write, input int addr,
                                input int data, input int expv);
        u_check.expect_apb(name, write, expv);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = APB_ADDR_W'(addr);
        pwdata  = write ? APB_DATA_W'(data) : '0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_coef(input string name, input int pos, input int coef,
                             input int expv, input int gap);
        u_check.expect_coef(name, pos, expv);
        in_valid = 1'b1;
        in_coef  = COEF_W'(coef);
        in_index = IDX_W'(pos);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        // Idle data differs from the last item so a stage loading without valid shows up
        in_coef  = ~in_coef;
        in_index = ~in_index;
        if (gap != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Waits for every queued result to come out, then reports the test
    task automatic finish_test();
        int new_errors;
        while (u_check.outstanding() != 0) begin
            @(posedge clk);
            #1;
        end
        new_errors = u_check.errors - errors_at_start;
        if (new_errors == 0) begin
            $display("Test %s: ok", cur_test);
            tests_ok++;
        end else begin
            $display("Test %s: %0d errors", cur_test, new_errors);
            tests_bad++;
        end
        errors_at_start = u_check.errors;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_coef  = '0;
        in_index = '0;
        load_trace();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        if (ops_total == 0) begin
            $display("No operations were read from the trace file");
            $display("Testbench failed");
            $finish;
        end else begin
            cur_test = name_q[0];
            for (int i = 0; i < ops_total; i++) begin
                if (name_q[i] != cur_test) begin
                    finish_test();
                    cur_test = name_q[i];
                end
                if (op_q[i] == "W") begin
                    apb_transfer(name_q[i], 1'b1, f1_q[i], f2_q[i], f3_q[i]);
                end else if (op_q[i] == "R") begin
                    apb_transfer(name_q[i], 1'b0, f1_q[i], 0, f2_q[i]);
                end else if (op_q[i] == "C") begin
                    send_coef(name_q[i], f1_q[i], f2_q[i], f3_q[i], f4_q[i]);
                end else if (op_q[i] == "S") begin
                    // Sweep of consecutive positions, back to back
                    for (int p = f1_q[i]; p < f1_q[i] + f2_q[i]; p++) begin
                        send_coef(name_q[i], p, f3_q[i], f4_q[i], 0);
                    end
                end else begin
                    $display("Unknown trace operation %s in test %s", op_q[i], name_q[i]);
                    load_errors++;
                end
            end
            finish_test();
            $display("Summary: %0d tests ok, %0d tests with errors, %0d errors, %0d trace problems",
                     tests_ok, tests_bad, u_check.errors, load_errors);
            if (tests_bad == 0 && u_check.errors == 0 && load_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // Budget of ten cycles per trace operation plus a margin for reset and draining
    initial begin
        wait (ops_total > 0);
        repeat (ops_total * 10 + 100) @(posedge clk);
        $display("The run did not finish within %0d clock cycles", ops_total * 10 + 100);
        $display("Testbench failed");
        $finish;
    end

endmodule
